// File: all.f
design/cnn_shape_pkg.sv
design/cnn_width_pkg.sv
design/stage2_cnn_kernel.sv
design/stage2_channel_sum.sv
design/stage2_cnn_core.sv
verification/stage2_cnn_core_checker.sv
verification/tb_stage2_cnn_core.sv

// File: design/cnn_shape_pkg.sv
//==========================================================================
// window shape, channel count and pipeline latencies of the second CNN
// convolution stage, shared by the RTL and the testbench
//==========================================================================

package cnn_shape_pkg;

	//==========================================================================
	// window geometry
	//==========================================================================

	// 5x5 window per input channel
	localparam int KX = 5;
	localparam int KY = 5;

	// taps per window, tap k = row * KX + column
	localparam int K_TAPS = KX * KY;

	// two input channels feed one output pixel
	localparam int N_IN_CH = 2;

	//==========================================================================
	// pipeline latencies in clock cycles
	//==========================================================================

	// product register, then adder tree register
	localparam int KERNEL_LATENCY = 2;

	// channel sum, bias and ReLU in one registered stage
	localparam int SUM_LATENCY = 1;

	// input valid to output pixel valid
	localparam int CORE_LATENCY = KERNEL_LATENCY + SUM_LATENCY;

endpackage

// File: design/cnn_width_pkg.sv
//==========================================================================
// bit widths and vector types of the datapath: weights, feature map
// elements, products, kernel sums, bias and output pixel
// flattened windows hold tap k at slice k
//==========================================================================

package cnn_width_pkg;

	// tap count for the flattened window types
	import cnn_shape_pkg::*;

	//==========================================================================
	// element widths
	//==========================================================================

	// signed weight
	localparam int W_BW = 8;

	// signed feature map element from stage 1
	localparam int I_BW = 20;

	// full product, no rounding
	localparam int M_BW = W_BW + I_BW;

	// 25 terms need 5 growth bits
	localparam int AK_BW = M_BW + $clog2(K_TAPS);

	// signed bias
	localparam int B_BW = 16;

	// two kernel sums plus bias, one bit per doubling
	localparam int O_BW = AK_BW + 2;

	//==========================================================================
	// types
	//==========================================================================

	typedef logic signed [W_BW-1:0]  weight_t;
	typedef logic signed [I_BW-1:0]  fmap_t;
	typedef logic signed [M_BW-1:0]  mul_t;
	typedef logic signed [AK_BW-1:0] kacc_t;
	typedef logic signed [B_BW-1:0]  bias_t;
	typedef logic signed [O_BW-1:0]  ofmap_t;

	// whole windows, tap k at [k*BW +: BW]
	typedef logic [K_TAPS*W_BW-1:0] weight_win_t;
	typedef logic [K_TAPS*I_BW-1:0] fmap_win_t;

endpackage

// File: design/stage2_channel_sum.sv
`timescale 1ns/1ps
//==========================================================================
// last stage of the second convolution: adds both kernel sums and the
// bias, clamps negative results to zero and registers the output pixel
//==========================================================================

module stage2_channel_sum
	import cnn_width_pkg::*;
(
	input  logic   clk,
	input  logic   reset_n,

	// kernel sums, valid together
	input  logic   i_in_valid,
	input  kacc_t  i_acc_ch0,
	input  kacc_t  i_acc_ch1,

	// bias level, held stable over a run
	input  bias_t  i_bias,

	// output pixel, one cycle after the sums
	output logic   o_ot_valid,
	output ofmap_t o_ot_fmap
);

	//==========================================================================
	// sum and bias
	//==========================================================================

	ofmap_t ext_ch0;
	ofmap_t ext_ch1;
	ofmap_t ext_bias;
	ofmap_t pixel_sum;
	ofmap_t pixel_relu;

	// sign extension to the output width
	assign ext_ch0  = ofmap_t'(i_acc_ch0);
	assign ext_ch1  = ofmap_t'(i_acc_ch1);
	assign ext_bias = ofmap_t'(i_bias);

	// two growth bits cover the worst case
	assign pixel_sum = ext_ch0 + ext_ch1 + ext_bias;

	// ReLU, negative goes to zero
	assign pixel_relu = pixel_sum[O_BW-1] ? '0 : pixel_sum;

	//==========================================================================
	// output register
	//==========================================================================

	logic   r_valid;
	ofmap_t r_fmap;

	// strobe follows input valid every cycle
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_valid <= 1'b0;
		end else begin
			r_valid <= i_in_valid;
		end
	end

	// pixel holds between windows
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_fmap <= '0;
		end else if (i_in_valid) begin
			r_fmap <= pixel_relu;
		end
	end

	assign o_ot_valid = r_valid;
	assign o_ot_fmap  = r_fmap;

endmodule

// File: design/stage2_cnn_core.sv
`timescale 1ns/1ps
//==========================================================================
// top of the second convolution stage: two 5x5 kernels, one per input
// channel, feed the channel sum; one window per cycle, output pixel
// valid three cycles after the window strobe, no back-pressure
//==========================================================================

module stage2_cnn_core
	import cnn_width_pkg::*;
(
	input  logic        clk,
	input  logic        reset_n,

	// window strobe, all window inputs sampled with it
	input  logic        i_in_valid,

	// feature map windows per channel
	input  fmap_win_t   i_fmap_ch0,
	input  fmap_win_t   i_fmap_ch1,

	// weight windows per channel
	input  weight_win_t i_weight_ch0,
	input  weight_win_t i_weight_ch1,

	// bias, used two cycles after the window
	input  bias_t       i_bias,

	// output pixel after ReLU
	output logic        o_ot_valid,
	output ofmap_t      o_ot_fmap
);

	//==========================================================================
	// kernels
	//==========================================================================

	// valid from channel 0 stands for both channels
	logic  kernel_valid;
	kacc_t acc_ch0;
	kacc_t acc_ch1;

	stage2_cnn_kernel u_kernel_ch0 (
		.clk             (clk),
		.reset_n         (reset_n),
		.i_in_valid      (i_in_valid),
		.i_in_fmap       (i_fmap_ch0),
		.i_cnn_weight    (i_weight_ch0),
		.o_ot_valid      (kernel_valid),
		.o_ot_kernel_acc (acc_ch0)
	);

	// same valid timing as channel 0, strobe left open
	stage2_cnn_kernel u_kernel_ch1 (
		.clk             (clk),
		.reset_n         (reset_n),
		.i_in_valid      (i_in_valid),
		.i_in_fmap       (i_fmap_ch1),
		.i_cnn_weight    (i_weight_ch1),
		.o_ot_valid      (),
		.o_ot_kernel_acc (acc_ch1)
	);

	//==========================================================================
	// channel sum, bias and ReLU
	//==========================================================================

	stage2_channel_sum u_channel_sum (
		.clk        (clk),
		.reset_n    (reset_n),
		.i_in_valid (kernel_valid),
		.i_acc_ch0  (acc_ch0),
		.i_acc_ch1  (acc_ch1),
		.i_bias     (i_bias),
		.o_ot_valid (o_ot_valid),
		.o_ot_fmap  (o_ot_fmap)
	);

endmodule

// File: design/stage2_cnn_kernel.sv
`timescale 1ns/1ps
//==========================================================================
// one input channel of the second convolution stage
// 25 signed products registered on the input valid, then an adder tree
// registered one cycle later; output valid follows input valid by two
//==========================================================================

module stage2_cnn_kernel
	import cnn_shape_pkg::*;
	import cnn_width_pkg::*;
(
	input  logic        clk,
	input  logic        reset_n,

	// window strobe and data, sampled together
	input  logic        i_in_valid,
	input  fmap_win_t   i_in_fmap,
	input  weight_win_t i_cnn_weight,

	// kernel sum, KERNEL_LATENCY cycles after the window
	output logic        o_ot_valid,
	output kacc_t       o_ot_kernel_acc
);

	//==========================================================================
	// valid pipeline
	//==========================================================================

	// bit 0 enables the sum register, top bit is the output valid
	logic [KERNEL_LATENCY-1:0] r_valid;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_valid <= '0;
		end else begin
			r_valid <= {r_valid[KERNEL_LATENCY-2:0], i_in_valid};
		end
	end

	//==========================================================================
	// products, fmap x weight per tap
	//==========================================================================

	mul_t mul   [K_TAPS];
	mul_t r_mul [K_TAPS];

	for (genvar k = 0; k < K_TAPS; k++) begin : gen_mul
		fmap_t   tap_fmap;
		weight_t tap_weight;

		// signed views of tap k
		assign tap_fmap   = i_in_fmap[k*I_BW +: I_BW];
		assign tap_weight = i_cnn_weight[k*W_BW +: W_BW];

		// 20x8 signed fits 28 bits exactly
		assign mul[k] = tap_fmap * tap_weight;
	end

	// hold the products while no window is offered
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int k = 0; k < K_TAPS; k++) begin
				r_mul[k] <= '0;
			end
		end else if (i_in_valid) begin
			for (int k = 0; k < K_TAPS; k++) begin
				r_mul[k] <= mul[k];
			end
		end
	end

	//==========================================================================
	// adder tree, row sums then the total of the rows
	//==========================================================================

	kacc_t row_sum [KY];
	kacc_t tree_sum;

	always_comb begin
		// one row of KX products
		for (int r = 0; r < KY; r++) begin
			row_sum[r] = '0;
			for (int c = 0; c < KX; c++) begin
				row_sum[r] = row_sum[r] + kacc_t'(r_mul[r*KX + c]);
			end
		end
		// rows into the kernel sum
		tree_sum = '0;
		for (int r = 0; r < KY; r++) begin
			tree_sum = tree_sum + row_sum[r];
		end
	end

	kacc_t r_acc_kernel;

	// sum taken in the cycle after the products were loaded
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_acc_kernel <= '0;
		end else if (r_valid[0]) begin
			r_acc_kernel <= tree_sum;
		end
	end

	assign o_ot_valid      = r_valid[KERNEL_LATENCY-1];
	assign o_ot_kernel_acc = r_acc_kernel;

endmodule

// File: verification/stage2_cnn_core_checker.sv
`timescale 1ns/1ps
//==========================================================================
// timing and sign assertions on the stage 2 CNN core
// bound into the top level by the testbench, which reads fail_count
//==========================================================================

module stage2_cnn_core_checker
	import cnn_shape_pkg::*;
	import cnn_width_pkg::*;
(
	input  logic   clk,
	input  logic   reset_n,
	input  logic   i_in_valid,
	input  logic   i_ot_valid,
	input  ofmap_t i_ot_fmap
);

	// failed assertions so far
	int fail_count = 0;

	// every window strobe comes back as a pixel strobe after the pipeline
	a_latency: assert property (@(posedge clk) disable iff (!reset_n)
		i_in_valid |-> ##CORE_LATENCY i_ot_valid)
	else begin
		$error("output valid missing %0d cycles after input valid", CORE_LATENCY);
		fail_count++;
	end

	// no pixel strobe while reset is held
	a_reset_valid: assert property (@(posedge clk) !reset_n |-> !i_ot_valid)
	else begin
		$error("output valid high during reset");
		fail_count++;
	end

	// ReLU output, sign bit clear on every pixel
	a_relu_sign: assert property (@(posedge clk) disable iff (!reset_n)
		i_ot_valid |-> !i_ot_fmap[O_BW-1])
	else begin
		$error("negative output pixel after ReLU");
		fail_count++;
	end

endmodule

// File: verification/tb_stage2_cnn_core.sv
`timescale 1ns/1ps
//==========================================================================
// testbench of the second convolution stage: directed tests for reset,
// tap order, extreme values, ReLU, streaming and reset in flight
// expected pixels come from a reference model of the window sums
//==========================================================================

module tb_stage2_cnn_core
	import cnn_shape_pkg::*;
	import cnn_width_pkg::*;
();

	localparam int      MAX_CYCLES = 2000;
	localparam fmap_t   FMAP_MIN   = fmap_t'(-(1 << (I_BW-1)));
	localparam fmap_t   FMAP_MAX   = fmap_t'((1 << (I_BW-1)) - 1);
	localparam weight_t WEIGHT_MIN = weight_t'(-(1 << (W_BW-1)));
	localparam weight_t WEIGHT_MAX = weight_t'((1 << (W_BW-1)) - 1);

	logic        clk;
	logic        reset_n;
	logic        in_valid;
	fmap_win_t   fmap_ch0;
	fmap_win_t   fmap_ch1;
	weight_win_t weight_ch0;
	weight_win_t weight_ch1;
	bias_t       bias;
	logic        ot_valid;
	ofmap_t      ot_fmap;

	// expected pixels and the cycle of their window
	longint      exp_q[$];
	int          stamp_q[$];
	longint      exp_val;
	int          stamp;
	int          cycles = 0;
	int          mismatch_errors = 0;
	int          other_errors = 0;
	logic [31:0] lfsr = 32'h4a1;

	stage2_cnn_core dut (
		.clk          (clk),
		.reset_n      (reset_n),
		.i_in_valid   (in_valid),
		.i_fmap_ch0   (fmap_ch0),
		.i_fmap_ch1   (fmap_ch1),
		.i_weight_ch0 (weight_ch0),
		.i_weight_ch1 (weight_ch1),
		.i_bias       (bias),
		.o_ot_valid   (ot_valid),
		.o_ot_fmap    (ot_fmap)
	);

	bind stage2_cnn_core stage2_cnn_core_checker u_checker (
		.clk        (clk),
		.reset_n    (reset_n),
		.i_in_valid (i_in_valid),
		.i_ot_valid (o_ot_valid),
		.i_ot_fmap  (o_ot_fmap)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//==========================================================================
	// random bits, reference model, checks
	//==========================================================================

	// 32-bit Fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// sum of fmap x weight over both windows, plus bias, then ReLU
	function automatic longint ref_pixel(input fmap_win_t f0, input fmap_win_t f1,
		input weight_win_t w0, input weight_win_t w1, input bias_t b);
		longint  acc;
		fmap_t   fa;
		fmap_t   fb;
		weight_t wa;
		weight_t wb;
		acc = longint'(b);
		for (int k = 0; k < K_TAPS; k++) begin
			fa = f0[k*I_BW +: I_BW];
			fb = f1[k*I_BW +: I_BW];
			wa = w0[k*W_BW +: W_BW];
			wb = w1[k*W_BW +: W_BW];
			acc += longint'(fa) * longint'(wa) + longint'(fb) * longint'(wb);
		end
		return (acc < 0) ? 0 : acc;
	endfunction

	task automatic check_value(input string name, input longint got, input longint expected);
		assert (got == expected) else begin
			$display("Mismatch %s: got %h expected %h", name, got, expected);
			mismatch_errors++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		other_errors++;
	endtask

	// inputs seen at the falling edge, pixels checked there too
	always @(negedge clk) begin
		if (!reset_n) begin
			exp_q.delete();
			stamp_q.delete();
		end else begin
			if (ot_valid) begin
				assert (exp_q.size() != 0)
				else report_failure("output valid with no window in flight");
				if (exp_q.size() != 0) begin
					exp_val = exp_q.pop_front();
					stamp   = stamp_q.pop_front();
					check_value("o_ot_fmap", ot_fmap, exp_val);
					assert (cycles - stamp == CORE_LATENCY)
					else report_failure($sformatf("pixel came %0d cycles after its window",
						cycles - stamp));
				end
			end
			if (in_valid) begin
				exp_q.push_back(ref_pixel(fmap_ch0, fmap_ch1, weight_ch0, weight_ch1, bias));
				stamp_q.push_back(cycles);
			end
		end
	end

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout, run went past %0d cycles", MAX_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	//==========================================================================
	// drivers
	//==========================================================================

	task automatic send_window(input fmap_win_t f0, input fmap_win_t f1,
		input weight_win_t w0, input weight_win_t w1);
		@(posedge clk);
		in_valid   <= 1'b1;
		fmap_ch0   <= f0;
		fmap_ch1   <= f1;
		weight_ch0 <= w0;
		weight_ch1 <= w1;
	endtask

	task automatic set_bias(input bias_t b);
		@(posedge clk);
		in_valid <= 1'b0;
		bias     <= b;
	endtask

	// stop the stream, wait for every pixel in flight
	task automatic drain();
		int waited;
		waited = 0;
		@(posedge clk);
		in_valid <= 1'b0;
		while (exp_q.size() != 0 && waited < 4 * CORE_LATENCY) begin
			@(posedge clk);
			waited++;
		end
		assert (exp_q.size() == 0)
		else report_failure($sformatf("%0d output pixels never came", exp_q.size()));
	endtask

	task automatic random_window(output fmap_win_t f, output weight_win_t w);
		for (int k = 0; k < K_TAPS; k++) begin
			f[k*I_BW +: I_BW] = take_bits(I_BW);
			w[k*W_BW +: W_BW] = take_bits(W_BW);
		end
	endtask

	//==========================================================================
	// directed tests
	//==========================================================================

	task automatic idle_after_reset();
		repeat (4) begin
			@(negedge clk);
			check_value("o_ot_valid", ot_valid, 0);
			check_value("o_ot_fmap", ot_fmap, 0);
		end
	endtask

	// one live tap per channel, ch1 walks the taps backwards
	task automatic walk_single_taps();
		fmap_win_t   f0;
		fmap_win_t   f1;
		weight_win_t w0;
		weight_win_t w1;
		set_bias(bias_t'(16'sh0123));
		for (int k = 0; k < K_TAPS; k++) begin
			f0 = '0;
			f1 = '0;
			w0 = '0;
			w1 = '0;
			f0[k*I_BW +: I_BW] = fmap_t'(4099 * k - 52000);
			w0[k*W_BW +: W_BW] = weight_t'(5 * k - 61);
			f1[(K_TAPS-1-k)*I_BW +: I_BW] = fmap_t'(7 - 1111 * k);
			w1[(K_TAPS-1-k)*W_BW +: W_BW] = weight_t'(k + 3);
			send_window(f0, f1, w0, w1);
		end
		drain();
	endtask

	task automatic drive_extreme_values();
		fmap_win_t   f0;
		fmap_win_t   f1;
		weight_win_t w0;
		weight_win_t w1;
		// largest positive sum, min x min everywhere
		set_bias(bias_t'(16'sh7fff));
		for (int k = 0; k < K_TAPS; k++) begin
			f0[k*I_BW +: I_BW] = FMAP_MIN;
			w0[k*W_BW +: W_BW] = WEIGHT_MIN;
		end
		f1 = f0;
		w1 = w0;
		send_window(f0, f1, w0, w1);
		drain();
		// both channels negative, most negative bias
		set_bias(bias_t'(16'sh8000));
		for (int k = 0; k < K_TAPS; k++) begin
			w0[k*W_BW +: W_BW] = WEIGHT_MAX;
			f1[k*I_BW +: I_BW] = FMAP_MAX;
		end
		send_window(f0, f1, w0, w1);
		drain();
		// signs alternate tap by tap
		set_bias('0);
		for (int k = 0; k < K_TAPS; k++) begin
			f0[k*I_BW +: I_BW] = (k % 2) ? FMAP_MAX : FMAP_MIN;
			w1[k*W_BW +: W_BW] = (k % 2) ? WEIGHT_MIN : WEIGHT_MAX;
		end
		send_window(f0, f1, w0, w1);
		drain();
	endtask

	// sums of -2, -1, 0 and +1 around the ReLU threshold
	task automatic probe_relu_threshold();
		fmap_win_t   f0;
		fmap_win_t   f1;
		weight_win_t w0;
		weight_win_t w1;
		set_bias(bias_t'(-1000));
		for (int p = 998; p <= 1001; p++) begin
			f0 = '0;
			f1 = '0;
			w0 = '0;
			w1 = '0;
			f0[0 +: I_BW] = fmap_t'(p);
			w0[0 +: W_BW] = weight_t'(1);
			send_window(f0, f1, w0, w1);
		end
		drain();
	endtask

	// 30 windows back to back, then 30 with gaps of 0 to 3 cycles
	task automatic stream_random_windows();
		fmap_win_t   f0;
		fmap_win_t   f1;
		weight_win_t w0;
		weight_win_t w1;
		int          gap;
		set_bias(bias_t'(take_bits(B_BW)));
		for (int n = 0; n < 60; n++) begin
			random_window(f0, w0);
			random_window(f1, w1);
			if (n >= 30) begin
				gap = take_bits(2);
				repeat (gap) begin
					@(posedge clk);
					in_valid <= 1'b0;
				end
			end
			send_window(f0, f1, w0, w1);
		end
		drain();
	endtask

	// reset lands while pixels are coming out
	task automatic reset_mid_stream();
		fmap_win_t   f0;
		fmap_win_t   f1;
		weight_win_t w0;
		weight_win_t w1;
		for (int n = 0; n < 4; n++) begin
			random_window(f0, w0);
			random_window(f1, w1);
			send_window(f0, f1, w0, w1);
		end
		@(posedge clk);
		in_valid <= 1'b0;
		reset_n  <= 1'b0;
		@(negedge clk);
		assert (ot_valid == 1'b0) else report_failure("output valid stayed high in reset");
		repeat (2) @(posedge clk);
		reset_n <= 1'b1;
		random_window(f0, w0);
		random_window(f1, w1);
		send_window(f0, f1, w0, w1);
		drain();
	endtask

	//==========================================================================
	// sequence
	//==========================================================================

	initial begin
		reset_n    = 1'b0;
		in_valid   = 1'b0;
		fmap_ch0   = '0;
		fmap_ch1   = '0;
		weight_ch0 = '0;
		weight_ch1 = '0;
		bias       = '0;
		repeat (8) @(posedge clk);
		reset_n <= 1'b1;
		idle_after_reset();
		walk_single_taps();
		drive_extreme_values();
		probe_relu_threshold();
		stream_random_windows();
		reset_mid_stream();
		$display("errors: %0d mismatches, %0d other, %0d checker", mismatch_errors,
			other_errors, dut.u_checker.fail_count);
		if (mismatch_errors + other_errors + dut.u_checker.fail_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
